/* flist.f */
+incdir+include
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/io_addr_decode.sv
verilog/io_frc.sv
verilog/io_interrupter.sv
verilog/io_read_return.sv
verilog/io_subsys_top.sv
tests/io_subsys_sva.sv
tests/io_subsys_tb.sv

/* Bender.yml */
package:
  name: io_subsys

export_include_dirs:
  - include

sources:
  - files:
      - verilog/io_pkg.sv
      - verilog/io_bus_if.sv
      - verilog/io_addr_decode.sv
      - verilog/io_frc.sv
      - verilog/io_interrupter.sv
      - verilog/io_read_return.sv
      - verilog/io_subsys_top.sv
  - target: test
    files:
      - tests/io_subsys_sva.sv
      - tests/io_subsys_tb.sv

/* tests/io_subsys_tb.sv */
// testbench for the io register slice, drives the bus and checks read data and interrupt levels
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_subsys_tb;
	import io_pkg::*;

	logic clk;
	logic i_reset;
	logic i_dma_io_we;
	logic [15:2] i_dma_io_wadr;
	logic [31:0] i_dma_io_wdata;
	logic i_dma_io_radr_en;
	logic [15:2] i_dma_io_radr;
	logic i_interrupt_0;
	logic [31:0] o_dma_io_rdata;
	logic o_frc_cntr_val_leq;
	logic o_g_interrupt;
	logic o_g_interrupt_1shot;

	logic sh_run; // shadow register state
	logic [31:0] sh_cnt;
	logic [31:0] sh_cmp;
	logic [1:0] sh_en;
	logic [1:0] sh_pend;
	logic [1:0] pend_set;
	logic [1:0] pend_clr;
	logic sh_leq;
	logic sh_leq_d;
	logic [2:0] sh_sync; // pin synchronizer plus edge flop
	io_reg_e wsel;
	logic chk_valid = 1'b0;
	logic [31:0] chk_exp;
	integer errors = 0;
	integer shot_cnt = 0;
	integer shot_base;
	integer seed;
	logic [31:0] rnd;
	logic leq_exp;

	io_subsys_top u_dut (.*);

	always #5 clk = ~clk;

	function automatic io_reg_e adr_to_reg(input logic [13:0] adr);
		case (adr)
			`IO_ADR_FRC_CTRL: return REG_FRC_CTRL;
			`IO_ADR_FRC_CNT: return REG_FRC_CNT;
			`IO_ADR_FRC_CMP: return REG_FRC_CMP;
			`IO_ADR_INT_EN: return REG_INT_EN;
			`IO_ADR_INT_PEND: return REG_INT_PEND;
			default: return REG_NONE;
		endcase
	endfunction

	function automatic logic [31:0] exp_read(input logic [13:0] adr);
		case (adr_to_reg(adr))
			REG_FRC_CTRL: return {31'd0, sh_run};
			REG_FRC_CNT: return sh_cnt;
			REG_FRC_CMP: return sh_cmp;
			REG_INT_EN: return {30'd0, sh_en};
			REG_INT_PEND: return {30'd0, sh_pend};
			default: return `IO_UNMAPPED_DATA;
		endcase
	endfunction

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg_sel(input io_reg_e got, input io_reg_e exp);
		if (got !== exp) begin
			$display("FAILED at %0t: read select %s expected %s", $time, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
		@(posedge clk);
		i_dma_io_we <= 1'b1;
		i_dma_io_wadr <= adr;
		i_dma_io_wdata <= data;
		@(posedge clk);
		i_dma_io_we <= 1'b0;
	endtask

	// back-to-back reads where the second pulse follows the first directly
	task automatic bus_read(input logic [13:0] adr_a, input logic [13:0] adr_b);
		@(posedge clk);
		i_dma_io_radr_en <= 1'b1;
		i_dma_io_radr <= adr_a;
		@(posedge clk);
		i_dma_io_radr <= adr_b;
		@(posedge clk);
		i_dma_io_radr_en <= 1'b0;
	endtask

	task automatic wait_g_irq(input logic level, input string what);
		integer i;
		i = 0;
		@(negedge clk);
		while (o_g_interrupt !== level && i < 50) begin
			@(negedge clk);
			i++;
		end
		if (o_g_interrupt !== level) begin
			$display("timeout while %s, global interrupt never went to %b", what, level);
			errors++;
		end
	endtask

	// level checked before and one cycle after a compare write lands
	task automatic cmp_step(input logic [31:0] value, input logic [31:0] count);
		bus_write(`IO_ADR_FRC_CMP, value);
		@(negedge clk);
		check_level(o_frc_cntr_val_leq, leq_exp, "compare level before update");
		leq_exp = (value <= count);
		@(negedge clk);
		check_level(o_frc_cntr_val_leq, leq_exp, "compare level after compare write");
	endtask

	// expected read captured before the edge applies writes
	always @(posedge clk) begin
		chk_valid = 1'b0;
		if (i_reset) begin
			sh_run = 1'b0;
			sh_cnt = '0;
			sh_cmp = '0;
			sh_en = '0;
			sh_pend = '0;
			sh_leq = 1'b1; // 0 <= 0
			sh_leq_d = 1'b1;
			sh_sync = '0;
		end else begin
			if (i_dma_io_radr_en) begin
				check_reg_sel(u_dut.u_bus.rd_sel, adr_to_reg(i_dma_io_radr));
				chk_exp = exp_read(i_dma_io_radr);
				chk_valid = 1'b1;
			end
			wsel = i_dma_io_we ? adr_to_reg(i_dma_io_wadr) : REG_NONE;
			pend_set[IRQ_EXT] = sh_sync[1] & ~sh_sync[2];
			pend_set[IRQ_TIMER] = sh_leq & ~sh_leq_d;
			pend_clr = (wsel == REG_INT_PEND) ? i_dma_io_wdata[1:0] : 2'b00;
			sh_pend = pend_set | (sh_pend & ~pend_clr);
			sh_sync = {sh_sync[1:0], i_interrupt_0};
			sh_leq_d = sh_leq;
			sh_leq = (sh_cmp <= sh_cnt);
			if (wsel == REG_FRC_CTRL && i_dma_io_wdata[1]) begin
				sh_cnt = '0;
			end else if (sh_run) begin
				sh_cnt = sh_cnt + 1;
			end
			if (wsel == REG_FRC_CTRL) sh_run = i_dma_io_wdata[0];
			if (wsel == REG_FRC_CMP) sh_cmp = i_dma_io_wdata;
			if (wsel == REG_INT_EN) sh_en = i_dma_io_wdata[1:0];
		end
	end

	always @(negedge clk) begin
		if (chk_valid) check_data(o_dma_io_rdata, chk_exp, "read data");
		if (o_g_interrupt_1shot === 1'b1) shot_cnt++;
	end

	initial begin
		#100us;
		$display("simulation ran past its time limit");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		seed = 32'h4f47bc72;
		clk = 1'b0;
		i_reset = 1'b1;
		i_dma_io_we = 1'b0;
		i_dma_io_wadr = '0;
		i_dma_io_wdata = '0;
		i_dma_io_radr_en = 1'b0;
		i_dma_io_radr = '0;
		i_interrupt_0 = 1'b0;
		repeat (8) @(posedge clk);
		i_reset <= 1'b0;

		bus_read(`IO_ADR_FRC_CTRL, `IO_ADR_FRC_CNT); // reset values
		bus_read(`IO_ADR_FRC_CMP, `IO_ADR_INT_EN);
		bus_read(`IO_ADR_INT_PEND, 14'h0123);
		@(negedge clk);
		check_data(o_dma_io_rdata, `IO_UNMAPPED_DATA, "unmapped read");
		check_level(o_g_interrupt, 1'b0, "global interrupt after reset");
		check_level(o_frc_cntr_val_leq, 1'b1, "compare level after reset");

		rnd = $random(seed); // register round trip
		bus_write(`IO_ADR_FRC_CMP, rnd);
		bus_read(`IO_ADR_FRC_CMP, `IO_ADR_FRC_CMP);
		@(negedge clk);
		check_data(o_dma_io_rdata, rnd, "compare round trip");
		rnd = $random(seed);
		bus_write(`IO_ADR_INT_EN, rnd);
		bus_read(`IO_ADR_INT_EN, `IO_ADR_FRC_CMP);
		rnd = $random(seed);
		bus_write(`IO_ADR_FRC_CTRL, rnd & ~32'h2);
		bus_read(`IO_ADR_FRC_CTRL, `IO_ADR_INT_EN);
		bus_write(`IO_ADR_INT_EN, 32'h0);
		bus_write(`IO_ADR_FRC_CTRL, 32'h2);
		bus_write(`IO_ADR_FRC_CMP, 32'h0);
		repeat (3) @(posedge clk);
		bus_write(`IO_ADR_INT_PEND, 32'h3);

		bus_write(`IO_ADR_FRC_CTRL, 32'h1); // counter runs 7 then 5 edges
		repeat (5) @(posedge clk);
		bus_write(`IO_ADR_FRC_CTRL, 32'h0);
		bus_read(`IO_ADR_FRC_CNT, `IO_ADR_FRC_CNT);
		@(negedge clk);
		check_data(o_dma_io_rdata, 32'd7, "count after first run");
		bus_write(`IO_ADR_FRC_CTRL, 32'h1);
		repeat (3) @(posedge clk);
		bus_write(`IO_ADR_FRC_CTRL, 32'h0);
		bus_read(`IO_ADR_FRC_CNT, `IO_ADR_FRC_CTRL);
		bus_write(`IO_ADR_FRC_CTRL, 32'h2);
		bus_read(`IO_ADR_FRC_CNT, `IO_ADR_FRC_CNT);
		@(negedge clk);
		check_data(o_dma_io_rdata, 32'd0, "count after clear");

		bus_write(`IO_ADR_FRC_CTRL, 32'h1); // freeze the count at 12
		repeat (10) @(posedge clk);
		bus_write(`IO_ADR_FRC_CTRL, 32'h0);
		leq_exp = 1'b1;
		cmp_step(32'd13, 32'd12);
		cmp_step(32'd12, 32'd12);
		cmp_step(32'd11, 32'd12);
		cmp_step(32'd21, 32'd12);
		cmp_step(32'd12, 32'd12);

		bus_write(`IO_ADR_INT_PEND, 32'h3); // external interrupt
		bus_write(`IO_ADR_INT_EN, 32'h1 << IRQ_EXT);
		shot_base = shot_cnt;
		@(posedge clk);
		i_interrupt_0 <= 1'b1;
		repeat (3) @(posedge clk);
		i_interrupt_0 <= 1'b0;
		wait_g_irq(1'b1, "waiting for the external interrupt");
		repeat (3) @(posedge clk);
		check_level(shot_cnt == shot_base + 1, 1'b1, "single 1shot pulse");
		bus_read(`IO_ADR_INT_PEND, `IO_ADR_INT_PEND);
		@(negedge clk);
		check_data(o_dma_io_rdata, 32'h1, "external pending bit");
		bus_write(`IO_ADR_INT_PEND, 32'h1);
		wait_g_irq(1'b0, "waiting for the interrupt to drop");

		cmp_step(32'd13, 32'd12); // timer crossing with the source disabled
		cmp_step(32'd12, 32'd12);
		bus_read(`IO_ADR_INT_PEND, `IO_ADR_INT_PEND);
		@(negedge clk);
		check_data(o_dma_io_rdata, 32'h1 << IRQ_TIMER, "timer pending bit");
		check_level(o_g_interrupt, 1'b0, "global interrupt with timer disabled");
		bus_write(`IO_ADR_INT_PEND, 32'h3);
		bus_read(`IO_ADR_INT_PEND, `IO_ADR_INT_PEND);
		@(negedge clk);
		check_data(o_dma_io_rdata, 32'h0, "pending after clear");

		repeat (2) @(posedge clk);
		$display("test finished with %0d errors", errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* tests/io_subsys_sva.sv */
// timing properties of the io slice outputs, bound onto the top level in simulation
`timescale 1ns/1ps

module io_subsys_sva (
	input logic clk,
	input logic i_reset,
	input logic [31:0] o_dma_io_rdata,
	input logic o_g_interrupt,
	input logic o_g_interrupt_1shot
);

	// pulse is one cycle wide
	a_shot_single: assert property (@(posedge clk) disable iff (i_reset)
		o_g_interrupt_1shot |=> !o_g_interrupt_1shot)
		else $error("1shot pulse lasted more than one cycle");

	// level still up the cycle after the pulse
	a_shot_level: assert property (@(posedge clk) disable iff (i_reset)
		o_g_interrupt_1shot |=> o_g_interrupt)
		else $error("global interrupt level dropped right after the 1shot pulse");

	// outputs clear on the edge after a reset sample
	a_reset_low: assert property (@(posedge clk)
		i_reset |=> (!o_g_interrupt && !o_g_interrupt_1shot && o_dma_io_rdata == 32'd0))
		else $error("outputs not cleared during reset");

endmodule

bind io_subsys_top io_subsys_sva u_sva (
	.clk(clk),
	.i_reset(i_reset),
	.o_dma_io_rdata(o_dma_io_rdata),
	.o_g_interrupt(o_g_interrupt),
	.o_g_interrupt_1shot(o_g_interrupt_1shot)
);

/* verilog/io_subsys_top.sv */
// top level of the io register slice, connects the decoder, timer, interrupter and read stage
`timescale 1ns/1ps

module io_subsys_top (
	input logic clk,
	input logic i_reset,
	input logic i_dma_io_we,
	input logic [15:2] i_dma_io_wadr,
	input logic [31:0] i_dma_io_wdata,
	input logic i_dma_io_radr_en,
	input logic [15:2] i_dma_io_radr,
	input logic i_interrupt_0,
	output logic [31:0] o_dma_io_rdata,
	output logic o_frc_cntr_val_leq,
	output logic o_g_interrupt,
	output logic o_g_interrupt_1shot
);

	logic [31:0] frc_ctrl;
	logic [31:0] frc_cnt;
	logic [31:0] frc_cmp;
	logic frc_leq; // timer compare level, also to the interrupter
	logic [1:0] int_en;
	logic [1:0] int_pend;

	io_bus_if u_bus ();

	io_addr_decode u_decode (
		.i_dma_io_we(i_dma_io_we),
		.i_dma_io_wadr(i_dma_io_wadr),
		.i_dma_io_wdata(i_dma_io_wdata),
		.i_dma_io_radr_en(i_dma_io_radr_en),
		.i_dma_io_radr(i_dma_io_radr),
		.o_bus(u_bus.decoder)
	);

	io_frc u_frc (
		.clk(clk),
		.i_reset(i_reset),
		.i_bus(u_bus.peripheral),
		.o_frc_ctrl(frc_ctrl),
		.o_frc_cnt(frc_cnt),
		.o_frc_cmp(frc_cmp),
		.o_frc_cntr_val_leq(frc_leq)
	);

	io_interrupter u_interrupter (
		.clk(clk),
		.i_reset(i_reset),
		.i_bus(u_bus.peripheral),
		.i_interrupt_0(i_interrupt_0),
		.i_frc_cntr_val_leq(frc_leq),
		.o_int_en(int_en),
		.o_int_pend(int_pend),
		.o_g_interrupt(o_g_interrupt),
		.o_g_interrupt_1shot(o_g_interrupt_1shot)
	);

	io_read_return u_read_return (
		.clk(clk),
		.i_reset(i_reset),
		.i_bus(u_bus.peripheral),
		.i_frc_ctrl(frc_ctrl),
		.i_frc_cnt(frc_cnt),
		.i_frc_cmp(frc_cmp),
		.i_int_en(int_en),
		.i_int_pend(int_pend),
		.o_dma_io_rdata(o_dma_io_rdata)
	);

	assign o_frc_cntr_val_leq = frc_leq;

endmodule

/* verilog/io_read_return.sv */
// read data stage of the io slice, registers the addressed register one cycle after a read pulse
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_read_return (
	input logic clk,
	input logic i_reset,
	io_bus_if.peripheral i_bus,
	input logic [31:0] i_frc_ctrl,
	input logic [31:0] i_frc_cnt,
	input logic [31:0] i_frc_cmp,
	input logic [1:0] i_int_en,
	input logic [1:0] i_int_pend,
	output logic [31:0] o_dma_io_rdata
);
	import io_pkg::*;

	logic [31:0] rdata_mux;

	always_comb begin
		case (i_bus.rd_sel)
			REG_FRC_CTRL: begin
				rdata_mux = i_frc_ctrl;
			end
			REG_FRC_CNT: begin
				rdata_mux = i_frc_cnt;
			end
			REG_FRC_CMP: begin
				rdata_mux = i_frc_cmp;
			end
			REG_INT_EN: begin
				rdata_mux = {30'd0, i_int_en};
			end
			REG_INT_PEND: begin
				rdata_mux = {30'd0, i_int_pend};
			end
			default: begin
				rdata_mux = `IO_UNMAPPED_DATA; // REG_NONE and spare codes
			end
		endcase
	end

	// holds the last read until the next pulse
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_dma_io_rdata <= 32'd0;
		end else if (i_bus.rd_en) begin
			o_dma_io_rdata <= rdata_mux;
		end
	end

endmodule

/* verilog/io_interrupter.sv */
// interrupt collector that merges the external pin and the timer compare into the global interrupt
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_interrupter (
	input logic clk,
	input logic i_reset,
	io_bus_if.peripheral i_bus,
	input logic i_interrupt_0,
	input logic i_frc_cntr_val_leq,
	output logic [1:0] o_int_en,
	output logic [1:0] o_int_pend,
	output logic o_g_interrupt,
	output logic o_g_interrupt_1shot
);
	import io_pkg::*;

	logic ext_s1;
	logic ext_s2;
	logic ext_s3; // previous synced value for the edge detect
	logic tmr_d;
	logic [`IO_IRQ_NUM-1:0] int_en;
	logic [`IO_IRQ_NUM-1:0] int_pend;
	logic [`IO_IRQ_NUM-1:0] pend_set;
	logic [`IO_IRQ_NUM-1:0] pend_clr;
	logic en_we;
	logic pend_we;
	logic g_next;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			ext_s1 <= 1'b0;
			ext_s2 <= 1'b0;
			ext_s3 <= 1'b0;
			tmr_d <= 1'b1; // compare level is high out of reset
		end else begin
			ext_s1 <= i_interrupt_0; // async pin
			ext_s2 <= ext_s1;
			ext_s3 <= ext_s2;
			tmr_d <= i_frc_cntr_val_leq;
		end
	end

	assign pend_set[IRQ_EXT] = ext_s2 & ~ext_s3;
	assign pend_set[IRQ_TIMER] = i_frc_cntr_val_leq & ~tmr_d;

	assign en_we = i_bus.wr_en & (i_bus.wr_sel == REG_INT_EN);
	assign pend_we = i_bus.wr_en & (i_bus.wr_sel == REG_INT_PEND);
	assign pend_clr = pend_we ? i_bus.wdata[`IO_IRQ_NUM-1:0] : '0;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			int_en <= '0;
		end else if (en_we) begin
			int_en <= i_bus.wdata[`IO_IRQ_NUM-1:0];
		end
	end

	// a new edge wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (i_reset) begin
			int_pend <= '0;
		end else begin
			int_pend <= pend_set | (int_pend & ~pend_clr);
		end
	end

	assign g_next = |(int_pend & int_en);

	// the pulse rises together with the level
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_g_interrupt <= 1'b0;
			o_g_interrupt_1shot <= 1'b0;
		end else begin
			o_g_interrupt <= g_next;
			o_g_interrupt_1shot <= g_next & ~o_g_interrupt;
		end
	end

	assign o_int_en = int_en;
	assign o_int_pend = int_pend;

endmodule

/* verilog/io_frc.sv */
// free-running counter with run control and compare register, drives the timer compare level
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_frc (
	input logic clk,
	input logic i_reset,
	io_bus_if.peripheral i_bus,
	output logic [31:0] o_frc_ctrl,
	output logic [31:0] o_frc_cnt,
	output logic [31:0] o_frc_cmp,
	output logic o_frc_cntr_val_leq
);
	import io_pkg::*;

	logic run;
	logic [`IO_FRC_WIDTH-1:0] cnt;
	logic [`IO_FRC_WIDTH-1:0] cmp;
	logic leq;
	logic ctrl_we;
	logic cmp_we;
	logic cnt_clr;

	assign ctrl_we = i_bus.wr_en & (i_bus.wr_sel == REG_FRC_CTRL);
	assign cmp_we = i_bus.wr_en & (i_bus.wr_sel == REG_FRC_CMP);
	assign cnt_clr = ctrl_we & i_bus.wdata[1]; // self-clearing, never stored

	always_ff @(posedge clk) begin
		if (i_reset) begin
			run <= 1'b0;
		end else if (ctrl_we) begin
			run <= i_bus.wdata[0];
		end
	end

	// clear beats increment, writes to the count are dropped
	always_ff @(posedge clk) begin
		if (i_reset) begin
			cnt <= '0;
		end else if (cnt_clr) begin
			cnt <= '0;
		end else if (run) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			cmp <= '0;
		end else if (cmp_we) begin
			cmp <= i_bus.wdata[`IO_FRC_WIDTH-1:0];
		end
	end

	// 0 <= 0 out of reset, so the level starts high
	always_ff @(posedge clk) begin
		if (i_reset) begin
			leq <= 1'b1;
		end else begin
			leq <= (cmp <= cnt); // one cycle behind the count
		end
	end

	assign o_frc_ctrl = {31'd0, run};
	assign o_frc_cnt = cnt;
	assign o_frc_cmp = cmp;
	assign o_frc_cntr_val_leq = leq;

endmodule

/* verilog/io_addr_decode.sv */
// combinational decoder that maps io bus word addresses onto register selects for the slice
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_addr_decode (
	input logic i_dma_io_we,
	input logic [15:2] i_dma_io_wadr,
	input logic [31:0] i_dma_io_wdata,
	input logic i_dma_io_radr_en,
	input logic [15:2] i_dma_io_radr,
	io_bus_if.decoder o_bus
);
	import io_pkg::*;

	io_reg_e wr_sel;
	io_reg_e rd_sel;

	// same lookup for both the write and the read address
	function automatic io_reg_e decode_adr(input logic [15:2] adr);
		io_reg_e sel;
		case (adr)
			`IO_ADR_FRC_CTRL: begin
				sel = REG_FRC_CTRL;
			end
			`IO_ADR_FRC_CNT: begin
				sel = REG_FRC_CNT;
			end
			`IO_ADR_FRC_CMP: begin
				sel = REG_FRC_CMP;
			end
			`IO_ADR_INT_EN: begin
				sel = REG_INT_EN;
			end
			`IO_ADR_INT_PEND: begin
				sel = REG_INT_PEND;
			end
			default: begin
				sel = REG_NONE; // not ours
			end
		endcase
		return sel;
	endfunction

	assign wr_sel = decode_adr(i_dma_io_wadr);
	assign rd_sel = decode_adr(i_dma_io_radr);

	// strobes pass straight through, targets filter on the select
	assign o_bus.wr_en = i_dma_io_we;
	assign o_bus.wr_sel = wr_sel;
	assign o_bus.wdata = i_dma_io_wdata;
	assign o_bus.rd_en = i_dma_io_radr_en;
	assign o_bus.rd_sel = rd_sel;

endmodule

/* verilog/io_bus_if.sv */
// decoded io bus between the address decoder and the register blocks, one instance per subsystem
`timescale 1ns/1ps

interface io_bus_if;
	import io_pkg::*;

	logic wr_en; // one-cycle write strobe
	io_reg_e wr_sel; // decoded write target
	logic [31:0] wdata;
	logic rd_en; // one-cycle read pulse
	io_reg_e rd_sel; // decoded read target

	modport decoder (
		output wr_en,
		output wr_sel,
		output wdata,
		output rd_en,
		output rd_sel
	);

	modport peripheral (
		input wr_en,
		input wr_sel,
		input wdata,
		input rd_en,
		input rd_sel
	);

endinterface

/* verilog/io_pkg.sv */
// shared types of the io register slice, imported by the decoder, the register blocks and the testbench
package io_pkg;

	// register selected by a bus address
	typedef enum logic [2:0] {
		REG_NONE     = 3'd0, // unmapped
		REG_FRC_CTRL = 3'd1,
		REG_FRC_CNT  = 3'd2, // read only
		REG_FRC_CMP  = 3'd3,
		REG_INT_EN   = 3'd4,
		REG_INT_PEND = 3'd5  // write 1 to clear
	} io_reg_e;

	// bit position of each interrupt source
	// in the enable and pending registers
	typedef enum logic [0:0] {
		IRQ_EXT   = 1'b0, // external pin
		IRQ_TIMER = 1'b1  // frc compare
	} io_irq_e;

endpackage

/* include/io_cfg.svh */
// fixed register map and widths of the io register slice, included by the RTL and the testbench
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// word addresses on io bus bits [15:2]
`define IO_ADR_FRC_CTRL 14'h3fc0
`define IO_ADR_FRC_CNT 14'h3fc1
`define IO_ADR_FRC_CMP 14'h3fc2
`define IO_ADR_INT_EN 14'h3fc4
`define IO_ADR_INT_PEND 14'h3fc5

// free-running counter and compare register width
`define IO_FRC_WIDTH 32

// read data returned for an address nobody claims
`define IO_UNMAPPED_DATA 32'hdeadbeef

// number of interrupt sources in the collector
`define IO_IRQ_NUM 2

`endif
